//--- source/dmaPkg.sv
`default_nettype none

package dmaPkg;

  localparam int AddrWidth = 16;
  localparam int DataWidth = 16;
  localparam int FifoDepth = 4;                       // must stay a power of two
  localparam int FifoPtrWidth = $clog2(FifoDepth);
  localparam int FifoCntWidth = $clog2(FifoDepth + 1);

  localparam logic [3:0] IntRegion = 4'hF;            // top nibble of internal memory

  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [AddrWidth-1:0]    count_t;            // element count
  typedef logic [2:0]              regAddr_t;
  typedef logic [FifoPtrWidth-1:0] fifoPtr_t;
  typedef logic [FifoCntWidth-1:0] fifoCnt_t;

  // register map
  localparam regAddr_t RegCtrl     = 3'd0;
  localparam regAddr_t RegSrcIndex = 3'd1;
  localparam regAddr_t RegSrcMod   = 3'd2;
  localparam regAddr_t RegDstIndex = 3'd3;
  localparam regAddr_t RegDstMod   = 3'd4;
  localparam regAddr_t RegCount    = 3'd5;

  localparam int CtrlEnable = 0;                      // enable bit of the control word

  typedef struct packed {
    logic     valid;
    regAddr_t addr;
    data_t    data;
  } regWrite_t;

  // one request to a memory port
  typedef struct packed {
    logic  en;
    logic  wr;
    addr_t addr;
    data_t wdata;
  } portReq_t;

  typedef struct packed {
    addr_t  srcIndex;
    addr_t  srcMod;
    addr_t  dstIndex;
    addr_t  dstMod;
    count_t count;
  } chanCfg_t;

  typedef enum logic [1:0] {
    Idle,
    Run,
    Done
  } seqState_t;

endpackage

`default_nettype wire

//--- source/dmaRegFile.sv
`timescale 1ns/1ps
`default_nettype none

module dmaRegFile
  import dmaPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  regWrite_t regWr,
  input  logic      busy,
  output chanCfg_t  cfg,
  output logic      start
);

  logic cfgWrEn;
  logic ctrlGo;

  // channel is locked from the start strobe until the sequencer is idle again
  assign cfgWrEn = regWr.valid && !busy && !start;
  assign ctrlGo  = cfgWrEn && (regWr.addr == RegCtrl) && regWr.data[CtrlEnable];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      cfg <= '0;
    end
    else if (cfgWrEn)
    begin
      case (regWr.addr)
        RegSrcIndex: cfg.srcIndex <= regWr.data;
        RegSrcMod:   cfg.srcMod   <= regWr.data;
        RegDstIndex: cfg.dstIndex <= regWr.data;
        RegDstMod:   cfg.dstMod   <= regWr.data;
        RegCount:    cfg.count    <= regWr.data;
        default:     ;                                // control only fires start
      endcase
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      start <= 1'b0;
    end
    else
    begin
      start <= ctrlGo;                                // one cycle after the write
    end
  end

  // start only reaches an idle sequencer
  assert property (@(posedge clk) disable iff (rst) start |-> !busy)
    else $error("start while busy");

  // and the sequencer takes it
  assert property (@(posedge clk) disable iff (rst) start |=> busy)
    else $error("start not accepted by sequencer");

endmodule

`default_nettype wire

//--- source/dmaAddrGen.sv
`timescale 1ns/1ps
`default_nettype none

module dmaAddrGen
  import dmaPkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  load,
  input  addr_t base,
  input  addr_t modifier,
  input  logic  step,
  output addr_t addr
);

  addr_t nextAddr;

  // wraps at the top of the address space
  assign nextAddr = addr + modifier;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      addr <= '0;
    end
    else if (load)
    begin
      addr <= base;                                   // index register
    end
    else if (step)
    begin
      addr <= nextAddr;
    end
  end

endmodule

`default_nettype wire

//--- source/dmaFifo.sv
`timescale 1ns/1ps
`default_nettype none

module dmaFifo
  import dmaPkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  push,
  input  data_t pushData,
  input  logic  pop,
  output data_t popData,
  output logic  full,
  output logic  empty
);

  data_t    mem [FifoDepth];
  fifoPtr_t wrPtr;
  fifoPtr_t rdPtr;
  fifoCnt_t count;

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wrPtr] <= pushData;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
      begin
        wrPtr <= wrPtr + 1'b1;                        // natural wrap
      end
      if (pop)
      begin
        rdPtr <= rdPtr + 1'b1;
      end
      count <= count + fifoCnt_t'(push) - fifoCnt_t'(pop);
    end
  end

  assign popData = mem[rdPtr];                        // head shown without a pop
  assign full    = (count == fifoCnt_t'(FifoDepth));
  assign empty   = (count == '0);

  assert property (@(posedge clk) disable iff (rst) push |-> !full)
    else $error("fifo push when full");

  assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
    else $error("fifo pop when empty");

endmodule

`default_nettype wire

//--- source/dmaSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module dmaSequencer
  import dmaPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  chanCfg_t cfg,
  input  logic     start,
  input  addr_t    srcAddr,
  input  addr_t    dstAddr,
  output logic     srcLoad,
  output logic     srcStep,
  output logic     dstLoad,
  output logic     dstStep,
  output logic     fifoPush,
  output data_t    fifoPushData,
  output logic     fifoPop,
  input  data_t    fifoPopData,
  input  logic     fifoFull,
  input  logic     fifoEmpty,
  input  data_t    intRdata,
  input  data_t    extRdata,
  output portReq_t intReq,
  output portReq_t extReq,
  output logic     busy,
  output logic     done
);

  seqState_t state;
  count_t    readsLeft;
  count_t    writesLeft;
  fifoCnt_t  held;                                    // buffered plus in flight
  logic      rdPending;
  logic      rdFromExt;
  logic      srcIsInt;
  logic      dstIsInt;
  logic      launch;
  logic      doRead;
  logic      doWrite;

  assign srcIsInt = (srcAddr[AddrWidth-1 -: 4] == IntRegion);
  assign dstIsInt = (dstAddr[AddrWidth-1 -: 4] == IntRegion);
  assign launch   = (state == Idle) && start;

  // write has priority when both ends share a port
  assign doWrite = (state == Run) && !fifoEmpty;
  assign doRead  = (state == Run) && (readsLeft != '0) && !fifoFull
                   && (held < fifoCnt_t'(FifoDepth)) && !(doWrite && (srcIsInt == dstIsInt));

  assign srcLoad = launch;
  assign dstLoad = launch;
  assign srcStep = doRead;
  assign dstStep = doWrite;

  assign fifoPush     = rdPending;                    // data is back one cycle later
  assign fifoPushData = rdFromExt ? extRdata : intRdata;
  assign fifoPop      = doWrite;

  assign busy = (state != Idle);
  assign done = (state == Done);

  always_comb
  begin
    intReq = '0;
    extReq = '0;
    if (doRead)
    begin
      if (srcIsInt)
      begin
        intReq.en   = 1'b1;
        intReq.addr = srcAddr;
      end
      else
      begin
        extReq.en   = 1'b1;
        extReq.addr = srcAddr;
      end
    end
    if (doWrite)
    begin
      if (dstIsInt)
      begin
        intReq = '{en: 1'b1, wr: 1'b1, addr: dstAddr, wdata: fifoPopData};
      end
      else
      begin
        extReq = '{en: 1'b1, wr: 1'b1, addr: dstAddr, wdata: fifoPopData};
      end
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state      <= Idle;
      readsLeft  <= '0;
      writesLeft <= '0;
      held       <= '0;
      rdPending  <= 1'b0;
      rdFromExt  <= 1'b0;
    end
    else
    begin
      rdPending <= doRead;
      rdFromExt <= !srcIsInt;                         // port the read went to
      held      <= held + fifoCnt_t'(doRead) - fifoCnt_t'(doWrite);
      if (doRead)
      begin
        readsLeft <= readsLeft - 1'b1;
      end
      if (doWrite)
      begin
        writesLeft <= writesLeft - 1'b1;
      end
      case (state)
        Idle:
        begin
          if (start)
          begin
            readsLeft  <= cfg.count;
            writesLeft <= cfg.count;
            state      <= (cfg.count == '0) ? Done : Run;   // empty block ends at once
          end
        end
        Run:
        begin
          if (doWrite && (writesLeft == count_t'(1)))
          begin
            state <= Done;
          end
        end
        Done:    state <= Idle;
        default: state <= Idle;
      endcase
    end
  end

  // one request per port per cycle
  assert property (@(posedge clk) disable iff (rst)
    (doRead && doWrite) |-> (intReq.en && extReq.en))
    else $error("read and write on one port");

  // nothing left behind when the block ends
  assert property (@(posedge clk) disable iff (rst)
    (state == Done) |-> (fifoEmpty && !rdPending))
    else $error("done with data still buffered");

endmodule

`default_nettype wire

//--- source/dmaTop.sv
`timescale 1ns/1ps
`default_nettype none

module dmaTop
  import dmaPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  regWrite_t regWr,
  output portReq_t  intReq,
  output portReq_t  extReq,
  input  data_t     intRdata,
  input  data_t     extRdata,
  output logic      done
);

  chanCfg_t cfg;
  logic     start;
  logic     busy;
  addr_t    srcAddr;
  addr_t    dstAddr;
  logic     srcLoad;
  logic     srcStep;
  logic     dstLoad;
  logic     dstStep;
  logic     fifoPush;
  data_t    fifoPushData;
  logic     fifoPop;
  data_t    fifoPopData;
  logic     fifoFull;
  logic     fifoEmpty;

  dmaRegFile iRegFile (
    .clk   (clk),
    .rst   (rst),
    .regWr (regWr),
    .busy  (busy),
    .cfg   (cfg),
    .start (start)
  );

  // source pointer
  dmaAddrGen iSrcGen (
    .clk      (clk),
    .rst      (rst),
    .load     (srcLoad),
    .base     (cfg.srcIndex),
    .modifier (cfg.srcMod),
    .step     (srcStep),
    .addr     (srcAddr)
  );

  // destination pointer
  dmaAddrGen iDstGen (
    .clk      (clk),
    .rst      (rst),
    .load     (dstLoad),
    .base     (cfg.dstIndex),
    .modifier (cfg.dstMod),
    .step     (dstStep),
    .addr     (dstAddr)
  );

  dmaFifo iFifo (
    .clk      (clk),
    .rst      (rst),
    .push     (fifoPush),
    .pushData (fifoPushData),
    .pop      (fifoPop),
    .popData  (fifoPopData),
    .full     (fifoFull),
    .empty    (fifoEmpty)
  );

  dmaSequencer iSequencer (
    .clk          (clk),
    .rst          (rst),
    .cfg          (cfg),
    .start        (start),
    .srcAddr      (srcAddr),
    .dstAddr      (dstAddr),
    .srcLoad      (srcLoad),
    .srcStep      (srcStep),
    .dstLoad      (dstLoad),
    .dstStep      (dstStep),
    .fifoPush     (fifoPush),
    .fifoPushData (fifoPushData),
    .fifoPop      (fifoPop),
    .fifoPopData  (fifoPopData),
    .fifoFull     (fifoFull),
    .fifoEmpty    (fifoEmpty),
    .intRdata     (intRdata),
    .extRdata     (extRdata),
    .intReq       (intReq),
    .extReq       (extReq),
    .busy         (busy),
    .done         (done)
  );

endmodule

`default_nettype wire

//--- tb/dmaMemModel.sv
`timescale 1ns/1ps
`default_nettype none

module dmaMemModel
  import dmaPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  portReq_t req,
  output data_t    rdata
);

  // whole address space, preloaded through the hierarchy
  data_t mem [2**AddrWidth];

  always @(posedge clk)
  begin
    if (req.en && req.wr)
    begin
      mem[req.addr] <= req.wdata;
    end
  end

  always @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      rdata <= '0;
    end
    else if (req.en && !req.wr)
    begin
      rdata <= mem[req.addr];                         // valid in the next cycle
    end
  end

endmodule

`default_nettype wire

//--- tb/dmaTb.sv
`timescale 1ns/1ps
`default_nettype none

module dmaTb
  import dmaPkg::*;
();

  localparam int MaxCount      = 64;
  localparam int TimeoutCycles = 2000;

  logic      clk = 1'b0;
  logic      rst;
  regWrite_t regWr;
  portReq_t  intReq;
  portReq_t  extReq;
  data_t     intRdata;
  data_t     extRdata;
  logic      done;

  integer    seed;
  int        errCount = 0;
  int        timeoutCount = 0;
  int        xferCount = 0;
  logic      armed;                                   // first start issued
  logic      clearCnt;
  int        rdCnt;
  int        wrCnt;
  int        expCount;
  addr_t     expRdAddr [MaxCount];
  addr_t     expWrAddr [MaxCount];
  data_t     expWrData [MaxCount];
  data_t     shadowInt [2**AddrWidth];
  data_t     shadowExt [2**AddrWidth];

  logic      intRd;
  logic      extRd;
  logic      intWr;
  logic      extWr;
  logic      anyRd;
  logic      anyWr;
  addr_t     rdAddr;
  addr_t     wrAddr;
  data_t     wrData;
  addr_t     rdExp;
  addr_t     wrExpAddr;
  data_t     wrExpData;

  always #10 clk = ~clk;

  dmaTop i_dut (
    .clk      (clk),
    .rst      (rst),
    .regWr    (regWr),
    .intReq   (intReq),
    .extReq   (extReq),
    .intRdata (intRdata),
    .extRdata (extRdata),
    .done     (done)
  );

  dmaMemModel iIntMem (.clk(clk), .rst(rst), .req(intReq), .rdata(intRdata));
  dmaMemModel iExtMem (.clk(clk), .rst(rst), .req(extReq), .rdata(extRdata));

  function automatic logic isInt(input addr_t a);
    return a[AddrWidth-1 -: 4] == IntRegion;
  endfunction

  assign intRd     = intReq.en && !intReq.wr;
  assign extRd     = extReq.en && !extReq.wr;
  assign intWr     = intReq.en && intReq.wr;
  assign extWr     = extReq.en && extReq.wr;
  assign anyRd     = intRd || extRd;
  assign anyWr     = intWr || extWr;
  assign rdAddr    = intRd ? intReq.addr : extReq.addr;
  assign wrAddr    = intWr ? intReq.addr : extReq.addr;
  assign wrData    = intWr ? intReq.wdata : extReq.wdata;
  assign rdExp     = expRdAddr[rdCnt % MaxCount];     // k-th predicted element
  assign wrExpAddr = expWrAddr[wrCnt % MaxCount];
  assign wrExpData = expWrData[wrCnt % MaxCount];

  // requests seen since the last start
  always @(posedge clk or posedge rst)
  begin
    if (rst || clearCnt)
    begin
      rdCnt <= 0;
      wrCnt <= 0;
    end
    else
    begin
      rdCnt <= rdCnt + int'(anyRd);
      wrCnt <= wrCnt + int'(anyWr);
    end
  end

  task automatic reportMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
    errCount++;
  endtask

  task automatic noteFailure(input string what);
    $display("ERROR: %s at %0t", what, $time);
    errCount++;
  endtask

  assert property (@(posedge clk) disable iff (rst)
    !armed |-> (!intReq.en && !extReq.en && !done))
    else noteFailure("port request or done before the first start");
  assert property (@(posedge clk) disable iff (rst) anyRd |-> (rdCnt < expCount))
    else noteFailure("read issued beyond the programmed count");
  assert property (@(posedge clk) disable iff (rst) anyRd |-> (rdAddr == rdExp))
    else reportMismatch($sampled(intRd) ? "intReq.addr" : "extReq.addr",
                        $sampled(rdAddr), $sampled(rdExp));
  assert property (@(posedge clk) disable iff (rst) anyRd |-> (intRd == isInt(rdExp)))
    else reportMismatch("intReq.en", $sampled(intRd), isInt($sampled(rdExp)));
  assert property (@(posedge clk) disable iff (rst) anyWr |-> (wrCnt < expCount))
    else noteFailure("write issued beyond the programmed count");
  assert property (@(posedge clk) disable iff (rst) anyWr |-> (wrAddr == wrExpAddr))
    else reportMismatch($sampled(intWr) ? "intReq.addr" : "extReq.addr",
                        $sampled(wrAddr), $sampled(wrExpAddr));
  assert property (@(posedge clk) disable iff (rst) anyWr |-> (wrData == wrExpData))
    else reportMismatch($sampled(intWr) ? "intReq.wdata" : "extReq.wdata",
                        $sampled(wrData), $sampled(wrExpData));
  assert property (@(posedge clk) disable iff (rst) anyWr |-> (intWr == isInt(wrExpAddr)))
    else reportMismatch("intReq.wr", $sampled(intWr), isInt($sampled(wrExpAddr)));
  assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else noteFailure("done held for more than one cycle");
  assert property (@(posedge clk) disable iff (rst) done |-> (wrCnt == expCount))
    else reportMismatch("write count", $sampled(wrCnt), $sampled(expCount));
  // a read lost under a write on a shared port shows up here
  assert property (@(posedge clk) disable iff (rst) done |-> (rdCnt == expCount))
    else reportMismatch("read count", $sampled(rdCnt), $sampled(expCount));

  task automatic fillMemories();
    int a;
    for (a = 0; a < 2**AddrWidth; a++)
    begin
      shadowInt[a]   = data_t'($random(seed));
      shadowExt[a]   = data_t'($random(seed));
      iIntMem.mem[a] = shadowInt[a];
      iExtMem.mem[a] = shadowExt[a];
    end
  endtask

  task automatic writeReg(input regAddr_t a, input data_t d);
    @(negedge clk);
    regWr = '{valid: 1'b1, addr: a, data: d};
    @(negedge clk);
    regWr = '0;
  endtask

  task automatic waitDone();
    int   cyc;
    logic seen;
    seen = 1'b0;
    for (cyc = 0; cyc < TimeoutCycles && !seen; cyc++)
    begin
      @(negedge clk);
      seen = done;
    end
    if (!seen)
    begin
      $display("ERROR: no done within %0d cycles", TimeoutCycles);
      timeoutCount++;
    end
    @(negedge clk);                                   // let the done cycle close
  endtask

  task automatic checkMemories();
    int a;
    for (a = 0; a < 2**AddrWidth; a++)
    begin
      assert (iIntMem.mem[a] == shadowInt[a])
        else reportMismatch($sformatf("intMem[%h]", a), iIntMem.mem[a], shadowInt[a]);
      assert (iExtMem.mem[a] == shadowExt[a])
        else reportMismatch($sformatf("extMem[%h]", a), iExtMem.mem[a], shadowExt[a]);
    end
  endtask

  // element k goes from src + k*sm to dst + k*dm
  task automatic runXfer(input addr_t src, input addr_t sm, input addr_t dst,
                         input addr_t dm, input count_t n, input logic poke);
    int k;
    for (k = 0; k < int'(n) && k < MaxCount; k++)
    begin
      expRdAddr[k] = addr_t'(int'(src) + k * int'(sm));   // wraps at 16 bits
      expWrAddr[k] = addr_t'(int'(dst) + k * int'(dm));
      expWrData[k] = isInt(expRdAddr[k]) ? shadowInt[expRdAddr[k]] : shadowExt[expRdAddr[k]];
    end
    for (k = 0; k < int'(n) && k < MaxCount; k++)
    begin
      if (isInt(expWrAddr[k]))
        shadowInt[expWrAddr[k]] = expWrData[k];
      else
        shadowExt[expWrAddr[k]] = expWrData[k];
    end
    expCount = int'(n);
    writeReg(RegSrcIndex, src);
    writeReg(RegSrcMod, sm);
    writeReg(RegDstIndex, dst);
    writeReg(RegDstMod, dm);
    writeReg(RegCount, n);
    armed    = 1'b1;
    clearCnt = 1'b1;
    writeReg(RegCtrl, 16'h0001);
    clearCnt = 1'b0;
    if (poke)
    begin
      writeReg(RegSrcMod, 16'd5);                     // all ignored while busy
      writeReg(RegDstMod, 16'd7);
      writeReg(RegCtrl, 16'h0001);
    end
    waitDone();
    checkMemories();
    xferCount++;
  endtask

  initial
  begin
    seed     = 32'h80b3_9ad0;
    rst      = 1'b1;
    regWr    = '0;
    armed    = 1'b0;
    clearCnt = 1'b0;
    expCount = 0;
    fillMemories();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (4) @(negedge clk);                        // ports stay quiet before start
    runXfer(16'hF010, 16'd1, 16'h2000, 16'd1, 16'd12, 1'b0);
    runXfer(16'h3000, 16'd2, 16'hF200, 16'd3, 16'd10, 1'b0);
    runXfer(16'hF400, 16'd1, 16'hF800, 16'd1, 16'd9, 1'b0);
    runXfer(16'h4000, 16'd1, 16'h5000, 16'd1, 16'd16, 1'b1);
    runXfer(16'h4100, 16'd1, 16'h5100, 16'd1, 16'd0, 1'b0);
    runXfer(16'hFFFC, 16'd1, 16'h6000, 16'd1, 16'd6, 1'b0);   // source wraps to 0000
    $display("summary: %0d transfers, %0d check errors, %0d timeouts",
             xferCount, errCount, timeoutCount);
    if (errCount == 0 && timeoutCount == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
source/dmaPkg.sv
source/dmaRegFile.sv
source/dmaAddrGen.sv
source/dmaFifo.sv
source/dmaSequencer.sv
source/dmaTop.sv
tb/dmaMemModel.sv
tb/dmaTb.sv
